// ==== rtl/slave_bus_pkg.sv ====
package slave_bus_pkg;

    // Crossing FIFO geometry
    localparam int FIFO_DEPTH_LOG2 = 3;
    localparam int FIFO_DEPTH = 1 << FIFO_DEPTH_LOG2;

    // Word memory geometry
    localparam int MEM_WORDS_LOG2 = 8;
    localparam int MEM_WORDS = 1 << MEM_WORDS_LOG2;
    localparam int BYTES_PER_WORD = 4;

    typedef logic [31:0] addr_t;
    typedef logic [7:0] len_t;
    typedef logic [3:0] id_t;
    typedef logic [8*BYTES_PER_WORD-1:0] data_t;
    typedef logic [BYTES_PER_WORD-1:0] strb_t;

    // One extra bit over the index to tell full from empty
    typedef logic [FIFO_DEPTH_LOG2:0] fifo_ptr_t;
    typedef logic [MEM_WORDS_LOG2-1:0] word_idx_t;

    // Shared by the write and read address channels
    typedef struct packed {
        addr_t addr;
        len_t  len;
        id_t   id;
    } addr_req_t;

    typedef struct packed {
        strb_t strb;
        logic  last;
        data_t data;
    } wr_beat_t;

    typedef struct packed {
        id_t   back_id;
        logic  last;
        data_t data;
    } rd_beat_t;

    typedef enum logic [1:0] {
        IDLE,
        WRITE,
        READ
    } mem_state_t;

endpackage

// ==== rtl/async_fifo.sv ====
`timescale 1ns/1ps

module async_fifo
    import slave_bus_pkg::*;
#(
    parameter int WIDTH = 32
) (
    input  logic             wr_clk,
    input  logic             wr_rst,
    input  logic             wr_en,
    input  logic [WIDTH-1:0] wr_data,
    output logic             full,

    input  logic             rd_clk,
    input  logic             rd_rst,
    input  logic             rd_en,
    output logic [WIDTH-1:0] rd_data,
    output logic             empty
);

    logic [WIDTH-1:0] mem [FIFO_DEPTH];

    fifo_ptr_t wr_bin;
    fifo_ptr_t wr_gray;
    fifo_ptr_t wr_bin_next;
    fifo_ptr_t rd_bin;
    fifo_ptr_t rd_gray;
    fifo_ptr_t rd_bin_next;

    // Gray pointers seen from the opposite domain
    fifo_ptr_t rd_gray_meta;
    fifo_ptr_t rd_gray_sync;
    fifo_ptr_t wr_gray_meta;
    fifo_ptr_t wr_gray_sync;

    logic wr_push;
    logic rd_pop;

    assign wr_push = wr_en & ~full;
    assign rd_pop = rd_en & ~empty;
    assign wr_bin_next = wr_bin + 1'b1;
    assign rd_bin_next = rd_bin + 1'b1;

    always_ff @(posedge wr_clk) begin
        if (wr_rst) begin
            wr_bin <= '0;
            wr_gray <= '0;
        end else if (wr_push) begin
            wr_bin <= wr_bin_next;
            wr_gray <= wr_bin_next ^ (wr_bin_next >> 1);
        end
    end

    always_ff @(posedge wr_clk) begin
        if (wr_push) begin
            mem[wr_bin[FIFO_DEPTH_LOG2-1:0]] <= wr_data;
        end
    end

    always_ff @(posedge wr_clk) begin
        if (wr_rst) begin
            rd_gray_meta <= '0;
            rd_gray_sync <= '0;
        end else begin
            rd_gray_meta <= rd_gray;
            rd_gray_sync <= rd_gray_meta;
        end
    end

    // Writer one lap ahead shows as the top two Gray bits inverted
    assign full = (wr_gray == {~rd_gray_sync[FIFO_DEPTH_LOG2 -: 2],
                               rd_gray_sync[FIFO_DEPTH_LOG2-2:0]});

    always_ff @(posedge rd_clk) begin
        if (rd_rst) begin
            rd_bin <= '0;
            rd_gray <= '0;
        end else if (rd_pop) begin
            rd_bin <= rd_bin_next;
            rd_gray <= rd_bin_next ^ (rd_bin_next >> 1);
        end
    end

    always_ff @(posedge rd_clk) begin
        if (rd_pop) begin
            rd_data <= mem[rd_bin[FIFO_DEPTH_LOG2-1:0]];
        end
    end

    always_ff @(posedge rd_clk) begin
        if (rd_rst) begin
            wr_gray_meta <= '0;
            wr_gray_sync <= '0;
        end else begin
            wr_gray_meta <= wr_gray;
            wr_gray_sync <= wr_gray_meta;
        end
    end

    assign empty = (rd_gray == wr_gray_sync);

endmodule

// ==== rtl/slave_axi_async.sv ====
`timescale 1ns/1ps

module slave_axi_async
    import slave_bus_pkg::*;
(
    input  logic      SLAVE_CLK,
    input  logic      SLAVE_RST,
    input  logic      BUS_CLK,
    input  logic      BUS_RST,

    input  addr_req_t bus_wr_addr,
    input  logic      bus_wr_addr_valid,
    output logic      bus_wr_addr_ready,
    input  wr_beat_t  bus_wr_data,
    input  logic      bus_wr_data_valid,
    output logic      bus_wr_data_ready,
    input  addr_req_t bus_rd_addr,
    input  logic      bus_rd_addr_valid,
    output logic      bus_rd_addr_ready,
    output rd_beat_t  bus_rd_data,
    output logic      bus_rd_data_valid,
    input  logic      bus_rd_data_ready,

    output addr_req_t slv_wr_addr,
    output logic      slv_wr_addr_valid,
    input  logic      slv_wr_addr_ready,
    output wr_beat_t  slv_wr_data,
    output logic      slv_wr_data_valid,
    input  logic      slv_wr_data_ready,
    output addr_req_t slv_rd_addr,
    output logic      slv_rd_addr_valid,
    input  logic      slv_rd_addr_ready,
    input  rd_beat_t  slv_rd_data,
    input  logic      slv_rd_data_valid,
    output logic      slv_rd_data_ready
);

    // Either domain in reset stalls every channel
    logic rst_all;
    assign rst_all = BUS_RST | SLAVE_RST;

    // Write address, bus to slave
    logic wr_addr_full;
    logic wr_addr_empty;
    logic wr_addr_rd_en;
    logic wr_addr_head_free;

    assign bus_wr_addr_ready = ~rst_all & ~wr_addr_full;
    assign slv_wr_addr_valid = ~rst_all & ~wr_addr_head_free;
    assign wr_addr_rd_en = ~wr_addr_empty &
                           (wr_addr_head_free | (slv_wr_addr_valid & slv_wr_addr_ready));

    always_ff @(posedge SLAVE_CLK) begin
        if (SLAVE_RST) begin
            wr_addr_head_free <= 1'b1;
        end else if (wr_addr_empty && slv_wr_addr_valid && slv_wr_addr_ready) begin
            wr_addr_head_free <= 1'b1;
        end else if (wr_addr_rd_en) begin
            wr_addr_head_free <= 1'b0;
        end
    end

    async_fifo #(.WIDTH($bits(addr_req_t))) wr_addr_fifo (
        .wr_clk  (BUS_CLK),
        .wr_rst  (BUS_RST),
        .wr_en   (bus_wr_addr_valid & bus_wr_addr_ready),
        .wr_data (bus_wr_addr),
        .full    (wr_addr_full),
        .rd_clk  (SLAVE_CLK),
        .rd_rst  (SLAVE_RST),
        .rd_en   (wr_addr_rd_en),
        .rd_data (slv_wr_addr),
        .empty   (wr_addr_empty)
    );

    // Write data, bus to slave
    logic wr_data_full;
    logic wr_data_empty;
    logic wr_data_rd_en;
    logic wr_data_head_free;

    assign bus_wr_data_ready = ~rst_all & ~wr_data_full;
    assign slv_wr_data_valid = ~rst_all & ~wr_data_head_free;
    assign wr_data_rd_en = ~wr_data_empty &
                           (wr_data_head_free | (slv_wr_data_valid & slv_wr_data_ready));

    always_ff @(posedge SLAVE_CLK) begin
        if (SLAVE_RST) begin
            wr_data_head_free <= 1'b1;
        end else if (wr_data_empty && slv_wr_data_valid && slv_wr_data_ready) begin
            wr_data_head_free <= 1'b1;
        end else if (wr_data_rd_en) begin
            wr_data_head_free <= 1'b0;
        end
    end

    async_fifo #(.WIDTH($bits(wr_beat_t))) wr_data_fifo (
        .wr_clk  (BUS_CLK),
        .wr_rst  (BUS_RST),
        .wr_en   (bus_wr_data_valid & bus_wr_data_ready),
        .wr_data (bus_wr_data),
        .full    (wr_data_full),
        .rd_clk  (SLAVE_CLK),
        .rd_rst  (SLAVE_RST),
        .rd_en   (wr_data_rd_en),
        .rd_data (slv_wr_data),
        .empty   (wr_data_empty)
    );

    // Read address, bus to slave
    logic rd_addr_full;
    logic rd_addr_empty;
    logic rd_addr_rd_en;
    logic rd_addr_head_free;

    assign bus_rd_addr_ready = ~rst_all & ~rd_addr_full;
    assign slv_rd_addr_valid = ~rst_all & ~rd_addr_head_free;
    assign rd_addr_rd_en = ~rd_addr_empty &
                           (rd_addr_head_free | (slv_rd_addr_valid & slv_rd_addr_ready));

    always_ff @(posedge SLAVE_CLK) begin
        if (SLAVE_RST) begin
            rd_addr_head_free <= 1'b1;
        end else if (rd_addr_empty && slv_rd_addr_valid && slv_rd_addr_ready) begin
            rd_addr_head_free <= 1'b1;
        end else if (rd_addr_rd_en) begin
            rd_addr_head_free <= 1'b0;
        end
    end

    async_fifo #(.WIDTH($bits(addr_req_t))) rd_addr_fifo (
        .wr_clk  (BUS_CLK),
        .wr_rst  (BUS_RST),
        .wr_en   (bus_rd_addr_valid & bus_rd_addr_ready),
        .wr_data (bus_rd_addr),
        .full    (rd_addr_full),
        .rd_clk  (SLAVE_CLK),
        .rd_rst  (SLAVE_RST),
        .rd_en   (rd_addr_rd_en),
        .rd_data (slv_rd_addr),
        .empty   (rd_addr_empty)
    );

    // Read data runs the other way, so its head flag lives on BUS_CLK
    logic rd_data_full;
    logic rd_data_empty;
    logic rd_data_rd_en;
    logic rd_data_head_free;

    assign slv_rd_data_ready = ~rst_all & ~rd_data_full;
    assign bus_rd_data_valid = ~rst_all & ~rd_data_head_free;
    assign rd_data_rd_en = ~rd_data_empty &
                           (rd_data_head_free | (bus_rd_data_valid & bus_rd_data_ready));

    always_ff @(posedge BUS_CLK) begin
        if (BUS_RST) begin
            rd_data_head_free <= 1'b1;
        end else if (rd_data_empty && bus_rd_data_valid && bus_rd_data_ready) begin
            rd_data_head_free <= 1'b1;
        end else if (rd_data_rd_en) begin
            rd_data_head_free <= 1'b0;
        end
    end

    async_fifo #(.WIDTH($bits(rd_beat_t))) rd_data_fifo (
        .wr_clk  (SLAVE_CLK),
        .wr_rst  (SLAVE_RST),
        .wr_en   (slv_rd_data_valid & slv_rd_data_ready),
        .wr_data (slv_rd_data),
        .full    (rd_data_full),
        .rd_clk  (BUS_CLK),
        .rd_rst  (BUS_RST),
        .rd_en   (rd_data_rd_en),
        .rd_data (bus_rd_data),
        .empty   (rd_data_empty)
    );

endmodule

// ==== rtl/slave_burst_mem.sv ====
`timescale 1ns/1ps

module slave_burst_mem
    import slave_bus_pkg::*;
(
    input  logic      SLAVE_CLK,
    input  logic      SLAVE_RST,

    input  addr_req_t slv_wr_addr,
    input  logic      slv_wr_addr_valid,
    output logic      slv_wr_addr_ready,
    input  wr_beat_t  slv_wr_data,
    input  logic      slv_wr_data_valid,
    output logic      slv_wr_data_ready,
    input  addr_req_t slv_rd_addr,
    input  logic      slv_rd_addr_valid,
    output logic      slv_rd_addr_ready,
    output rd_beat_t  slv_rd_data,
    output logic      slv_rd_data_valid,
    input  logic      slv_rd_data_ready
);

    data_t mem [MEM_WORDS];

    mem_state_t state;
    word_idx_t  word_idx;
    len_t       beats_left;
    id_t        cur_id;

    // Holds the readies low for the first cycle out of reset
    logic active;

    logic wr_addr_xfer;
    logic rd_addr_xfer;
    logic wr_beat_xfer;
    logic rd_beat_xfer;
    logic rd_load;

    // Write requests win over reads in IDLE
    assign slv_wr_addr_ready = active & (state == IDLE);
    assign slv_rd_addr_ready = active & (state == IDLE) & ~slv_wr_addr_valid;
    assign slv_wr_data_ready = active & (state == WRITE);

    assign wr_addr_xfer = slv_wr_addr_valid & slv_wr_addr_ready;
    assign rd_addr_xfer = slv_rd_addr_valid & slv_rd_addr_ready;
    assign wr_beat_xfer = slv_wr_data_valid & slv_wr_data_ready;
    assign rd_beat_xfer = slv_rd_data_valid & slv_rd_data_ready;

    // Next read beat goes out when the slot is empty or being taken
    assign rd_load = (state == READ) & ~(rd_beat_xfer & slv_rd_data.last) &
                     (~slv_rd_data_valid | slv_rd_data_ready);

    always_ff @(posedge SLAVE_CLK) begin
        if (SLAVE_RST) begin
            active <= 1'b0;
            state <= IDLE;
            word_idx <= '0;
            beats_left <= '0;
            cur_id <= '0;
            slv_rd_data_valid <= 1'b0;
        end else begin
            active <= 1'b1;
            case (state)
                IDLE: begin
                    if (wr_addr_xfer) begin
                        state <= WRITE;
                        word_idx <= slv_wr_addr.addr[MEM_WORDS_LOG2+1:2];
                        beats_left <= slv_wr_addr.len;
                    end else if (rd_addr_xfer) begin
                        state <= READ;
                        word_idx <= slv_rd_addr.addr[MEM_WORDS_LOG2+1:2];
                        beats_left <= slv_rd_addr.len;
                        cur_id <= slv_rd_addr.id;
                    end
                end
                WRITE: begin
                    if (wr_beat_xfer) begin
                        word_idx <= word_idx + 1'b1;
                        beats_left <= beats_left - 1'b1;
                        if (slv_wr_data.last) begin
                            state <= IDLE;
                        end
                    end
                end
                READ: begin
                    if (rd_beat_xfer && slv_rd_data.last) begin
                        slv_rd_data_valid <= 1'b0;
                        state <= IDLE;
                    end else if (rd_load) begin
                        slv_rd_data_valid <= 1'b1;
                        word_idx <= word_idx + 1'b1;
                        beats_left <= beats_left - 1'b1;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // Byte merge under the strobes
    always_ff @(posedge SLAVE_CLK) begin
        if (state == WRITE && wr_beat_xfer) begin
            for (int b = 0; b < BYTES_PER_WORD; b++) begin
                if (slv_wr_data.strb[b]) begin
                    mem[word_idx][8*b +: 8] <= slv_wr_data.data[8*b +: 8];
                end
            end
        end
    end

    always_ff @(posedge SLAVE_CLK) begin
        if (rd_load) begin
            slv_rd_data.data <= mem[word_idx];
            slv_rd_data.back_id <= cur_id;
            slv_rd_data.last <= (beats_left == '0);
        end
    end

endmodule

// ==== rtl/slave_subsys_top.sv ====
`timescale 1ns/1ps

module slave_subsys_top
    import slave_bus_pkg::*;
(
    input  logic      SLAVE_CLK,
    input  logic      SLAVE_RST,
    input  logic      BUS_CLK,
    input  logic      BUS_RST,

    input  addr_req_t bus_wr_addr,
    input  logic      bus_wr_addr_valid,
    output logic      bus_wr_addr_ready,
    input  wr_beat_t  bus_wr_data,
    input  logic      bus_wr_data_valid,
    output logic      bus_wr_data_ready,
    input  addr_req_t bus_rd_addr,
    input  logic      bus_rd_addr_valid,
    output logic      bus_rd_addr_ready,
    output rd_beat_t  bus_rd_data,
    output logic      bus_rd_data_valid,
    input  logic      bus_rd_data_ready
);

    // Slave side channels, all on SLAVE_CLK
    addr_req_t slv_wr_addr;
    logic      slv_wr_addr_valid;
    logic      slv_wr_addr_ready;
    wr_beat_t  slv_wr_data;
    logic      slv_wr_data_valid;
    logic      slv_wr_data_ready;
    addr_req_t slv_rd_addr;
    logic      slv_rd_addr_valid;
    logic      slv_rd_addr_ready;
    rd_beat_t  slv_rd_data;
    logic      slv_rd_data_valid;
    logic      slv_rd_data_ready;

    slave_axi_async u_axi_async (
        .SLAVE_CLK         (SLAVE_CLK),
        .SLAVE_RST         (SLAVE_RST),
        .BUS_CLK           (BUS_CLK),
        .BUS_RST           (BUS_RST),
        .bus_wr_addr       (bus_wr_addr),
        .bus_wr_addr_valid (bus_wr_addr_valid),
        .bus_wr_addr_ready (bus_wr_addr_ready),
        .bus_wr_data       (bus_wr_data),
        .bus_wr_data_valid (bus_wr_data_valid),
        .bus_wr_data_ready (bus_wr_data_ready),
        .bus_rd_addr       (bus_rd_addr),
        .bus_rd_addr_valid (bus_rd_addr_valid),
        .bus_rd_addr_ready (bus_rd_addr_ready),
        .bus_rd_data       (bus_rd_data),
        .bus_rd_data_valid (bus_rd_data_valid),
        .bus_rd_data_ready (bus_rd_data_ready),
        .slv_wr_addr       (slv_wr_addr),
        .slv_wr_addr_valid (slv_wr_addr_valid),
        .slv_wr_addr_ready (slv_wr_addr_ready),
        .slv_wr_data       (slv_wr_data),
        .slv_wr_data_valid (slv_wr_data_valid),
        .slv_wr_data_ready (slv_wr_data_ready),
        .slv_rd_addr       (slv_rd_addr),
        .slv_rd_addr_valid (slv_rd_addr_valid),
        .slv_rd_addr_ready (slv_rd_addr_ready),
        .slv_rd_data       (slv_rd_data),
        .slv_rd_data_valid (slv_rd_data_valid),
        .slv_rd_data_ready (slv_rd_data_ready)
    );

    slave_burst_mem u_burst_mem (
        .SLAVE_CLK         (SLAVE_CLK),
        .SLAVE_RST         (SLAVE_RST),
        .slv_wr_addr       (slv_wr_addr),
        .slv_wr_addr_valid (slv_wr_addr_valid),
        .slv_wr_addr_ready (slv_wr_addr_ready),
        .slv_wr_data       (slv_wr_data),
        .slv_wr_data_valid (slv_wr_data_valid),
        .slv_wr_data_ready (slv_wr_data_ready),
        .slv_rd_addr       (slv_rd_addr),
        .slv_rd_addr_valid (slv_rd_addr_valid),
        .slv_rd_addr_ready (slv_rd_addr_ready),
        .slv_rd_data       (slv_rd_data),
        .slv_rd_data_valid (slv_rd_data_valid),
        .slv_rd_data_ready (slv_rd_data_ready)
    );

endmodule

// ==== test/tb_clk_gen.sv ====
`timescale 1ns/1ps

module tb_clk_gen #(
    parameter int PERIOD_NS  = 10,
    parameter int RST_CYCLES = 2
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // Synchronous reset released on a rising edge of this clock
    initial begin
        rst = 1'b1;
        repeat (RST_CYCLES) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

// ==== test/slave_subsys_props.sv ====
`timescale 1ns/1ps

module slave_subsys_props
    import slave_bus_pkg::*;
(
    input logic      SLAVE_CLK,
    input logic      SLAVE_RST,
    input logic      BUS_CLK,
    input logic      BUS_RST,
    input logic      bus_wr_addr_ready,
    input logic      bus_wr_data_ready,
    input addr_req_t bus_rd_addr,
    input logic      bus_rd_addr_valid,
    input logic      bus_rd_addr_ready,
    input rd_beat_t  bus_rd_data,
    input logic      bus_rd_data_valid,
    input logic      bus_rd_data_ready,
    input addr_req_t slv_wr_addr,
    input logic      slv_wr_addr_valid,
    input logic      slv_wr_addr_ready,
    input wr_beat_t  slv_wr_data,
    input logic      slv_wr_data_valid,
    input logic      slv_wr_data_ready,
    input addr_req_t slv_rd_addr,
    input logic      slv_rd_addr_valid,
    input logic      slv_rd_addr_ready,
    input rd_beat_t  slv_rd_data,
    input logic      slv_rd_data_valid,
    input logic      slv_rd_data_ready
);

    localparam int NUM_IDS = 1 << $bits(id_t);

    int prop_errs = 0;

    // Beats seen so far in the open burst of each ID, and its requested length
    logic [8:0] beat_cnt [NUM_IDS];
    len_t       burst_len [NUM_IDS];

    logic rst_any;
    assign rst_any = BUS_RST | SLAVE_RST;

    always_ff @(posedge BUS_CLK) begin
        if (BUS_RST) begin
            for (int i = 0; i < NUM_IDS; i++) begin
                beat_cnt[i] <= '0;
                burst_len[i] <= '1;
            end
        end else begin
            if (bus_rd_addr_valid && bus_rd_addr_ready) begin
                burst_len[bus_rd_addr.id] <= bus_rd_addr.len;
            end
            if (bus_rd_data_valid && bus_rd_data_ready) begin
                if (bus_rd_data.last) begin
                    beat_cnt[bus_rd_data.back_id] <= '0;
                end else begin
                    beat_cnt[bus_rd_data.back_id] <= beat_cnt[bus_rd_data.back_id] + 1'b1;
                end
            end
        end
    end

    rd_data_hold: assert property (@(posedge BUS_CLK) disable iff (rst_any)
        bus_rd_data_valid && !bus_rd_data_ready |=>
            bus_rd_data_valid && $stable(bus_rd_data))
    else begin
        $error("Bus read data dropped or changed before ready");
        prop_errs++;
    end

    wr_addr_hold: assert property (@(posedge SLAVE_CLK) disable iff (rst_any)
        slv_wr_addr_valid && !slv_wr_addr_ready |=>
            slv_wr_addr_valid && $stable(slv_wr_addr))
    else begin
        $error("Slave write address dropped or changed before ready");
        prop_errs++;
    end

    wr_data_hold: assert property (@(posedge SLAVE_CLK) disable iff (rst_any)
        slv_wr_data_valid && !slv_wr_data_ready |=>
            slv_wr_data_valid && $stable(slv_wr_data))
    else begin
        $error("Slave write data dropped or changed before ready");
        prop_errs++;
    end

    rd_addr_hold: assert property (@(posedge SLAVE_CLK) disable iff (rst_any)
        slv_rd_addr_valid && !slv_rd_addr_ready |=>
            slv_rd_addr_valid && $stable(slv_rd_addr))
    else begin
        $error("Slave read address dropped or changed before ready");
        prop_errs++;
    end

    slv_rd_data_hold: assert property (@(posedge SLAVE_CLK) disable iff (rst_any)
        slv_rd_data_valid && !slv_rd_data_ready |=>
            slv_rd_data_valid && $stable(slv_rd_data))
    else begin
        $error("Slave read data dropped or changed before ready");
        prop_errs++;
    end

    bus_side_quiet: assert property (@(posedge BUS_CLK)
        rst_any |-> !bus_wr_addr_ready && !bus_wr_data_ready &&
                    !bus_rd_addr_ready && !bus_rd_data_valid)
    else begin
        $error("Bus side ready or valid high during reset");
        prop_errs++;
    end

    slv_side_quiet: assert property (@(posedge SLAVE_CLK)
        rst_any |-> !slv_wr_addr_valid && !slv_wr_data_valid &&
                    !slv_rd_addr_valid && !slv_rd_data_ready)
    else begin
        $error("Slave side ready or valid high during reset");
        prop_errs++;
    end

    burst_length: assert property (@(posedge BUS_CLK) disable iff (rst_any)
        bus_rd_data_valid && bus_rd_data_ready |->
            beat_cnt[bus_rd_data.back_id] <= burst_len[bus_rd_data.back_id])
    else begin
        $error("Read burst returned more than len+1 beats");
        prop_errs++;
    end

endmodule

bind slave_axi_async slave_subsys_props props (.*);

// ==== test/tb_slave_subsys.sv ====
`timescale 1ns/1ps

module tb_slave_subsys
    import slave_bus_pkg::*;
();

    localparam int SEED = 32'h1077_c8f9;

    logic      SLAVE_CLK;
    logic      SLAVE_RST;
    logic      BUS_CLK;
    logic      BUS_RST;
    addr_req_t bus_wr_addr;
    logic      bus_wr_addr_valid;
    logic      bus_wr_addr_ready;
    wr_beat_t  bus_wr_data;
    logic      bus_wr_data_valid;
    logic      bus_wr_data_ready;
    addr_req_t bus_rd_addr;
    logic      bus_rd_addr_valid;
    logic      bus_rd_addr_ready;
    rd_beat_t  bus_rd_data;
    logic      bus_rd_data_valid;
    logic      bus_rd_data_ready;

    // Byte-wide reference memory
    logic [7:0] ref_mem [MEM_WORDS * BYTES_PER_WORD];
    data_t      wdata [256];
    strb_t      wstrb [256];
    rd_beat_t   exp_q [$];

    logic       stall_pat [1024];
    logic [9:0] stall_idx = '0;
    logic       stall_en = 1'b0;

    string cur_test = "reset";
    int    test_errs = 0;
    int    prop_errs_seen = 0;
    int    n_pass = 0;
    int    n_fail = 0;
    int    beats_issued = 1;

    tb_clk_gen #(.PERIOD_NS(10), .RST_CYCLES(2)) slave_clk_gen (
        .clk (SLAVE_CLK),
        .rst (SLAVE_RST)
    );

    tb_clk_gen #(.PERIOD_NS(14), .RST_CYCLES(2)) bus_clk_gen (
        .clk (BUS_CLK),
        .rst (BUS_RST)
    );

    slave_subsys_top dut (.*);

    function automatic int word_of(input addr_t addr, input int beat);
        return ((addr >> 2) + beat) % MEM_WORDS;
    endfunction

    function automatic void model_write(input int word, input data_t data, input strb_t strb);
        for (int b = 0; b < BYTES_PER_WORD; b++) begin
            if (strb[b]) begin
                ref_mem[word * BYTES_PER_WORD + b] = data[8*b +: 8];
            end
        end
    endfunction

    function automatic data_t model_word(input int word);
        data_t value;
        for (int b = 0; b < BYTES_PER_WORD; b++) begin
            value[8*b +: 8] = ref_mem[word * BYTES_PER_WORD + b];
        end
        return value;
    endfunction

    function automatic string beat_text(input rd_beat_t beat);
        return $sformatf("id=%0h last=%0b data=%h", beat.back_id, beat.last, beat.data);
    endfunction

    task automatic fill_random(input int beats);
        for (int i = 0; i < beats; i++) begin
            wdata[i] = $urandom;
            wstrb[i] = 4'hf;
        end
    endtask

    // Called right after a BUS_CLK edge; returns right after the last transfer
    task automatic write_burst(input addr_t addr, input len_t len, input id_t id);
        addr_req_t req;
        wr_beat_t  beat;
        int        i;
        req.addr = addr;
        req.len = len;
        req.id = id;
        bus_wr_addr <= req;
        bus_wr_addr_valid <= 1'b1;
        beats_issued++;
        @(posedge BUS_CLK);
        while (!bus_wr_addr_ready) @(posedge BUS_CLK);
        bus_wr_addr_valid <= 1'b0;
        for (i = 0; i <= len; i++) begin
            beat.strb = wstrb[i];
            beat.last = (i == len);
            beat.data = wdata[i];
            bus_wr_data <= beat;
            bus_wr_data_valid <= 1'b1;
            model_write(word_of(addr, i), wdata[i], wstrb[i]);
            beats_issued++;
            @(posedge BUS_CLK);
            while (!bus_wr_data_ready) @(posedge BUS_CLK);
        end
        bus_wr_data_valid <= 1'b0;
    endtask

    // Expected beats are queued before the request goes out
    task automatic read_burst(input addr_t addr, input len_t len, input id_t id);
        addr_req_t req;
        rd_beat_t  beat;
        int        i;
        for (i = 0; i <= len; i++) begin
            beat.back_id = id;
            beat.last = (i == len);
            beat.data = model_word(word_of(addr, i));
            exp_q.push_back(beat);
        end
        beats_issued += int'(len) + 2;
        req.addr = addr;
        req.len = len;
        req.id = id;
        bus_rd_addr <= req;
        bus_rd_addr_valid <= 1'b1;
        @(posedge BUS_CLK);
        while (!bus_rd_addr_ready) @(posedge BUS_CLK);
        bus_rd_addr_valid <= 1'b0;
    endtask

    // Quiet window afterwards catches surplus beats
    task automatic drain_reads();
        while (exp_q.size() != 0) @(posedge BUS_CLK);
        repeat (16) @(posedge BUS_CLK);
    endtask

    task automatic start_test(input string name);
        cur_test = name;
        test_errs = 0;
    endtask

    task automatic finish_test();
        int errs;
        errs = test_errs + (dut.u_axi_async.props.prop_errs - prop_errs_seen);
        prop_errs_seen = dut.u_axi_async.props.prop_errs;
        if (errs == 0) begin
            n_pass++;
            $display("Test %s: passed", cur_test);
        end else begin
            n_fail++;
            $display("Test %s: failed with %0d errors", cur_test, errs);
        end
    endtask

    always @(posedge BUS_CLK) begin
        bus_rd_data_ready <= stall_en ? stall_pat[stall_idx] : 1'b1;
        stall_idx <= stall_idx + 1'b1;
    end

    always @(posedge BUS_CLK) begin
        if (BUS_RST || SLAVE_RST) begin
            assert (!bus_wr_addr_ready && !bus_wr_data_ready &&
                    !bus_rd_addr_ready && !bus_rd_data_valid)
            else begin
                $display("Test %s: a ready or valid is high during reset", cur_test);
                test_errs++;
            end
        end
    end

    // Read data checker
    always @(posedge BUS_CLK) begin
        rd_beat_t exp_beat;
        if (bus_rd_data_valid && bus_rd_data_ready) begin
            assert (exp_q.size() != 0)
            else begin
                $display("Test %s: read beat arrived with no request outstanding", cur_test);
                test_errs++;
            end
            if (exp_q.size() != 0) begin
                exp_beat = exp_q.pop_front();
                assert (bus_rd_data === exp_beat)
                else begin
                    $display("Mismatch %s: expected %s, actual %s", cur_test,
                             beat_text(exp_beat), beat_text(bus_rd_data));
                    test_errs++;
                end
            end
        end
    end

    initial begin : watchdog
        int cycles;
        cycles = 0;
        while (cycles < 200 * beats_issued) begin
            @(posedge BUS_CLK);
            cycles++;
        end
        $display("Timeout: test %s made no progress after %0d bus cycles", cur_test, cycles);
        $display("RESULT: FAIL");
        $finish;
    end

    initial begin
        bus_wr_addr = '0;
        bus_wr_addr_valid = 1'b0;
        bus_wr_data = '0;
        bus_wr_data_valid = 1'b0;
        bus_rd_addr = '0;
        bus_rd_addr_valid = 1'b0;
        bus_rd_data_ready = 1'b0;
        void'($urandom(SEED));
        for (int i = 0; i < 1024; i++) begin
            stall_pat[i] = ($urandom % 3) != 0;
        end

        start_test("reset");
        while (BUS_RST !== 1'b0 || SLAVE_RST !== 1'b0) @(posedge BUS_CLK);
        @(posedge BUS_CLK);
        finish_test();

        start_test("full_strobe");
        fill_random(4);
        write_burst(32'h0000_0040, 8'd3, 4'd1);
        read_burst(32'h0000_0040, 8'd3, 4'd2);
        drain_reads();
        finish_test();

        start_test("partial_strobe");
        for (int i = 0; i < 4; i++) begin
            wdata[i] = 32'h1122_3344 + i;
            wstrb[i] = 4'hf;
        end
        write_burst(32'h0000_0080, 8'd3, 4'd0);
        for (int i = 0; i < 4; i++) begin
            wdata[i] = $urandom;
            wstrb[i] = $urandom;
        end
        write_burst(32'h0000_0080, 8'd3, 4'd0);
        read_burst(32'h0000_0080, 8'd3, 4'd7);
        drain_reads();
        finish_test();

        // Distinct IDs while several requests are outstanding
        start_test("id_and_last");
        fill_random(16);
        write_burst(32'h0000_0100, 8'd15, 4'd2);
        read_burst(32'h0000_0100, 8'd0, 4'd3);
        read_burst(32'h0000_0104, 8'd2, 4'd4);
        read_burst(32'h0000_0110, 8'd7, 4'd5);
        read_burst(32'h0000_0120, 8'd3, 4'd6);
        drain_reads();
        finish_test();

        start_test("back_pressure");
        fill_random(8);
        write_burst(32'h0000_0180, 8'd7, 4'd3);
        stall_en <= 1'b1;
        read_burst(32'h0000_0180, 8'd7, 4'd8);
        read_burst(32'h0000_0184, 8'd3, 4'd9);
        read_burst(32'h0000_0100, 8'd15, 4'd10);
        read_burst(32'h0000_0190, 8'd1, 4'd11);
        read_burst(32'h0000_0108, 8'd0, 4'd12);
        drain_reads();
        stall_en <= 1'b0;
        finish_test();

        // Words 253 to 2, and the read address carries bits above the memory size
        start_test("address_wrap");
        fill_random(6);
        write_burst(32'h0000_03f4, 8'd5, 4'd4);
        read_burst(32'h0000_13f4, 8'd5, 4'd13);
        drain_reads();
        finish_test();

        $display("Tests run: %0d, passed: %0d, failed: %0d", n_pass + n_fail, n_pass, n_fail);
        if (n_fail == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
rtl/slave_bus_pkg.sv
rtl/async_fifo.sv
rtl/slave_axi_async.sv
rtl/slave_burst_mem.sv
rtl/slave_subsys_top.sv
test/tb_clk_gen.sv
test/slave_subsys_props.sv
test/tb_slave_subsys.sv

// ==== Bender.yml ====
package:
  name: slave_subsys

sources:
  - rtl/slave_bus_pkg.sv
  - rtl/async_fifo.sv
  - rtl/slave_axi_async.sv
  - rtl/slave_burst_mem.sv
  - rtl/slave_subsys_top.sv
  - target: test
    files:
      - test/tb_clk_gen.sv
      - test/slave_subsys_props.sv
      - test/tb_slave_subsys.sv
